// File: include/erx_config.svh
`ifndef ERX_CONFIG_SVH
`define ERX_CONFIG_SVH

// Chip ID, a write to this ID in dstaddr[31:20] is a read response
`define ERX_ID 12'h800

// Queue sizing
`define ERX_FIFO_AW 4          // log2 of FIFO depth
`define ERX_PFULL_MARGIN 4     // Free slots left at prog_full

// Register bus
`define ERX_MI_AW 4            // Register address width
`define ERX_REG_CFG 0          // Enable and remap mode
`define ERX_REG_SEL 1          // Remap select mask
`define ERX_REG_PAT 2          // Remap pattern

`endif

// File: logic/erx_pkg.sv
`default_nettype none

package erx_pkg;

   typedef logic [31:0] addr_t;      // Mesh address
   typedef logic [31:0] data_t;      // Mesh data word
   typedef logic [3:0]  ctrlmode_t;
   typedef logic [1:0]  datamode_t;
   typedef logic [11:0] chipid_t;    // Upper address field
   typedef logic [7:0]  frame_t;     // Parallel frame bits
   typedef logic [63:0] beat_t;      // Parallel data bits

   // 104-bit mesh packet, spare sits at the old access bit
   typedef struct packed
   {
      addr_t     srcaddr;   // 103:72
      data_t     data;      // 71:40
      addr_t     dstaddr;   // 39:8
      ctrlmode_t ctrlmode;  // 7:4
      datamode_t datamode;  // 3:2
      logic      write;     // 1
      logic      spare;     // 0, always low
   } emesh_packet_t;

   // Codes 2 and 3 behave as NONE
   typedef enum logic [1:0]
   {
      REMAP_NONE   = 2'b00,
      REMAP_STATIC = 2'b01
   } remap_mode_e;

   typedef enum logic [0:0]
   {
      IDLE  = 1'b0,  // Waiting for beat 0
      BEAT1 = 1'b1   // Beat 0 latched
   } proto_state_e;

   typedef struct packed
   {
      logic        rx_enable;
      remap_mode_e remap_mode;
      chipid_t     remap_sel;      // Bits to replace
      chipid_t     remap_pattern;  // Replacement bits
   } erx_cfg_t;

endpackage

`default_nettype wire

// File: logic/erx_cfg.sv
`timescale 1ns/1ps
`default_nettype none

`include "erx_config.svh"

module erx_cfg
(
   input  logic                    rx_lclk_div4,
   input  logic                    rst_n,
   input  logic                    mi_en,
   input  logic                    mi_we,
   input  logic [`ERX_MI_AW-1:0]   mi_addr,
   input  erx_pkg::data_t          mi_din,
   output erx_pkg::data_t          mi_dout,
   output erx_pkg::erx_cfg_t       cfg
);

   import erx_pkg::*;

   logic  wr_cfg;
   logic  wr_sel;
   logic  wr_pat;
   logic  rd_en;
   data_t rd_data;

   // Address decode
   assign wr_cfg = mi_en && mi_we && (mi_addr == `ERX_MI_AW'(`ERX_REG_CFG));
   assign wr_sel = mi_en && mi_we && (mi_addr == `ERX_MI_AW'(`ERX_REG_SEL));
   assign wr_pat = mi_en && mi_we && (mi_addr == `ERX_MI_AW'(`ERX_REG_PAT));
   assign rd_en  = mi_en && !mi_we;

   // Setting registers
   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         cfg.rx_enable     <= 1'b1;        // Receiver on out of reset
         cfg.remap_mode    <= REMAP_NONE;
         cfg.remap_sel     <= '0;
         cfg.remap_pattern <= '0;
      end
      else
      begin
         if (wr_cfg)
         begin
            cfg.rx_enable  <= mi_din[0];
            cfg.remap_mode <= remap_mode_e'(mi_din[2:1]);
         end
         if (wr_sel)
            cfg.remap_sel <= mi_din[11:0];     // Mask
         if (wr_pat)
            cfg.remap_pattern <= mi_din[11:0]; // Pattern
      end
   end

   // Readback select, unmapped reads 0
   always_comb
   begin
      case (mi_addr)
         `ERX_MI_AW'(`ERX_REG_CFG): rd_data = data_t'({cfg.remap_mode, cfg.rx_enable});
         `ERX_MI_AW'(`ERX_REG_SEL): rd_data = data_t'(cfg.remap_sel);
         `ERX_MI_AW'(`ERX_REG_PAT): rd_data = data_t'(cfg.remap_pattern);
         default:                   rd_data = '0;
      endcase
   end

   // Registered readback, valid cycle after read
   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
         mi_dout <= '0;
      else if (rd_en)
         mi_dout <= rd_data;
   end

endmodule

`default_nettype wire

// File: logic/erx_protocol.sv
`timescale 1ns/1ps
`default_nettype none

module erx_protocol
(
   input  logic                    rx_lclk_div4,
   input  logic                    rst_n,
   input  logic                    rx_enable,
   input  erx_pkg::frame_t         frame_par,
   input  erx_pkg::beat_t          data_par,
   output logic                    access,
   output erx_pkg::emesh_packet_t  packet
);

   import erx_pkg::*;

   proto_state_e state;
   logic         frame_on;     // Frame bits all ones
   ctrlmode_t    b0_ctrlmode;  // Beat 0 fields
   datamode_t    b0_datamode;
   logic         b0_write;
   addr_t        b0_dstaddr;

   assign frame_on = (frame_par == '1);

   // Frame FSM and access pulse
   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         state  <= IDLE;
         access <= 1'b0;
      end
      else
      begin
         access <= 1'b0;                     // One-cycle pulse
         case (state)
            IDLE:
            begin
               if (rx_enable && frame_on)
                  state <= BEAT1;            // Beat 0 seen
            end
            BEAT1:
            begin
               access <= rx_enable && frame_on;  // Anything else aborts
               state  <= IDLE;
            end
            default:
               state <= IDLE;
         endcase
      end
   end

   // Beat 0 capture, control byte and dstaddr
   always_ff @(posedge rx_lclk_div4)
   begin
      if (state == IDLE && frame_on)
      begin
         b0_ctrlmode <= data_par[63:60];
         b0_datamode <= data_par[59:58];
         b0_write    <= data_par[57];       // Bit 56 reserved
         b0_dstaddr  <= data_par[55:24];
      end
   end

   // Packet assembled on the beat 1 edge
   always_ff @(posedge rx_lclk_div4)
   begin
      if (state == BEAT1)
      begin
         packet.srcaddr  <= data_par[31:0];
         packet.data     <= data_par[63:32];
         packet.dstaddr  <= b0_dstaddr;
         packet.ctrlmode <= b0_ctrlmode;
         packet.datamode <= b0_datamode;
         packet.write    <= b0_write;
         packet.spare    <= 1'b0;
      end
   end

endmodule

`default_nettype wire

// File: logic/erx_remap.sv
`timescale 1ns/1ps
`default_nettype none

`include "erx_config.svh"

module erx_remap
(
   input  logic                    rx_lclk_div4,
   input  logic                    rst_n,
   input  erx_pkg::remap_mode_e    remap_mode,
   input  erx_pkg::chipid_t        remap_sel,
   input  erx_pkg::chipid_t        remap_pattern,
   input  logic                    in_access,
   input  erx_pkg::emesh_packet_t  in_packet,
   output logic                    out_access,
   output erx_pkg::emesh_packet_t  out_packet
);

   import erx_pkg::*;

   chipid_t dst_id;
   chipid_t static_id;
   logic    is_rr;      // Read response, no remap
   logic    do_remap;

   assign dst_id    = in_packet.dstaddr[31:20];
   assign is_rr     = in_packet.write && (dst_id == `ERX_ID);
   assign do_remap  = (remap_mode == REMAP_STATIC) && !is_rr;
   assign static_id = (dst_id & ~remap_sel) | (remap_pattern & remap_sel);  // Masked replace

   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
         out_access <= 1'b0;
      else
         out_access <= in_access;
   end

   // Payload stage
   always_ff @(posedge rx_lclk_div4)
   begin
      out_packet <= in_packet;
      if (do_remap)
         out_packet.dstaddr[31:20] <= static_id;
   end

endmodule

`default_nettype wire

// File: logic/erx_disty.sv
`timescale 1ns/1ps
`default_nettype none

`include "erx_config.svh"

module erx_disty
(
   input  logic                    in_access,
   input  erx_pkg::emesh_packet_t  in_packet,
   input  logic                    wr_pfull,
   input  logic                    rd_pfull,
   input  logic                    rr_pfull,
   output logic                    wr_push,
   output logic                    rd_push,
   output logic                    rr_push,
   output logic                    rx_wr_wait,
   output logic                    rx_rd_wait
);

   import erx_pkg::*;

   chipid_t dst_id;
   logic    to_self;    // Destination is this chip

   assign dst_id  = in_packet.dstaddr[31:20];
   assign to_self = (dst_id == `ERX_ID);

   // Queue select
   assign wr_push = in_access && in_packet.write && !to_self;  // Plain write
   assign rr_push = in_access && in_packet.write && to_self;   // Read response
   assign rd_push = in_access && !in_packet.write;             // Read request

   // Pushback to the remote sender
   assign rx_wr_wait = wr_pfull || rr_pfull;  // Write channel carries both
   assign rx_rd_wait = rd_pfull;

endmodule

`default_nettype wire

// File: logic/erx_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "erx_config.svh"

module erx_fifo
(
   input  logic                    rx_lclk_div4,
   input  logic                    rst_n,
   input  logic                    push,
   input  erx_pkg::emesh_packet_t  din,
   input  logic                    wait_in,
   output logic                    access,
   output erx_pkg::emesh_packet_t  dout,
   output logic                    prog_full
);

   import erx_pkg::*;

   localparam int AW = `ERX_FIFO_AW;
   localparam logic [AW:0] DEPTH = (AW+1)'(2**AW);
   localparam logic [AW:0] PFULL_LVL = DEPTH - (AW+1)'(`ERX_PFULL_MARGIN);

   emesh_packet_t mem [2**AW];
   logic [AW-1:0] wr_ptr;
   logic [AW-1:0] rd_ptr;
   logic [AW:0]   count;     // RAM plus output register
   logic [AW:0]   ram_cnt;
   logic          do_push;
   logic          pop;
   logic          load;

   assign pop       = access && !wait_in;        // Consumed this edge
   assign do_push   = push && (count != DEPTH);  // Full drops the push
   assign ram_cnt   = count - {{AW{1'b0}}, access};
   assign load      = (ram_cnt != '0) && (!access || pop);
   assign prog_full = (count >= PFULL_LVL);

   // Storage
   always_ff @(posedge rx_lclk_div4)
   begin
      if (do_push)
         mem[wr_ptr] <= din;
      if (load)
         dout <= mem[rd_ptr];  // Show-ahead output register
   end

   // Pointers, occupancy and output valid
   always_ff @(posedge rx_lclk_div4 or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count  <= '0;
         access <= 1'b0;
      end
      else
      begin
         if (do_push)
            wr_ptr <= wr_ptr + 1'b1;
         if (load)
            rd_ptr <= rd_ptr + 1'b1;
         case ({do_push, pop})
            2'b10:   count <= count + 1'b1;
            2'b01:   count <= count - 1'b1;
            default: count <= count;
         endcase
         if (load)
            access <= 1'b1;
         else if (pop)
            access <= 1'b0;  // Drained
      end
   end

endmodule

`default_nettype wire

// File: logic/erx.sv
`timescale 1ns/1ps
`default_nettype none

`include "erx_config.svh"

module erx
(
   input  logic                    rx_lclk_div4,
   input  logic                    rst_n,
   input  erx_pkg::frame_t         frame_par,
   input  erx_pkg::beat_t          data_par,
   input  logic                    mi_en,
   input  logic                    mi_we,
   input  logic [`ERX_MI_AW-1:0]   mi_addr,
   input  erx_pkg::data_t          mi_din,
   output erx_pkg::data_t          mi_dout,
   output logic                    rxwr_access,
   output erx_pkg::emesh_packet_t  rxwr_packet,
   input  logic                    rxwr_wait,
   output logic                    rxrd_access,
   output erx_pkg::emesh_packet_t  rxrd_packet,
   input  logic                    rxrd_wait,
   output logic                    rxrr_access,
   output erx_pkg::emesh_packet_t  rxrr_packet,
   input  logic                    rxrr_wait,
   output logic                    rx_wr_wait,
   output logic                    rx_rd_wait
);

   import erx_pkg::*;

   erx_cfg_t      cfg;
   logic          proto_access;  // Frame decoder out
   emesh_packet_t proto_packet;
   logic          remap_access;  // Remap stage out
   emesh_packet_t remap_packet;
   logic          wr_push;
   logic          rd_push;
   logic          rr_push;
   logic          wr_pfull;
   logic          rd_pfull;
   logic          rr_pfull;

   erx_cfg erx_cfg
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .mi_dout      (mi_dout),
      .cfg          (cfg)
   );

   erx_protocol erx_protocol
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .rx_enable    (cfg.rx_enable),
      .frame_par    (frame_par),
      .data_par     (data_par),
      .access       (proto_access),
      .packet       (proto_packet)
   );

   erx_remap erx_remap
   (
      .rx_lclk_div4  (rx_lclk_div4),
      .rst_n         (rst_n),
      .remap_mode    (cfg.remap_mode),
      .remap_sel     (cfg.remap_sel),
      .remap_pattern (cfg.remap_pattern),
      .in_access     (proto_access),
      .in_packet     (proto_packet),
      .out_access    (remap_access),
      .out_packet    (remap_packet)
   );

   erx_disty erx_disty
   (
      .in_access  (remap_access),
      .in_packet  (remap_packet),
      .wr_pfull   (wr_pfull),
      .rd_pfull   (rd_pfull),
      .rr_pfull   (rr_pfull),
      .wr_push    (wr_push),
      .rd_push    (rd_push),
      .rr_push    (rr_push),
      .rx_wr_wait (rx_wr_wait),
      .rx_rd_wait (rx_rd_wait)
   );

   // Write queue, payload shared across all three
   erx_fifo rxwr_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .push         (wr_push),
      .din          (remap_packet),
      .wait_in      (rxwr_wait),
      .access       (rxwr_access),
      .dout         (rxwr_packet),
      .prog_full    (wr_pfull)
   );

   // Read request queue
   erx_fifo rxrd_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .push         (rd_push),
      .din          (remap_packet),
      .wait_in      (rxrd_wait),
      .access       (rxrd_access),
      .dout         (rxrd_packet),
      .prog_full    (rd_pfull)
   );

   // Read response queue
   erx_fifo rxrr_fifo
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .push         (rr_push),
      .din          (remap_packet),
      .wait_in      (rxrr_wait),
      .access       (rxrr_access),
      .dout         (rxrr_packet),
      .prog_full    (rr_pfull)
   );

endmodule

`default_nettype wire

// File: bench/erx_checker.sv
`timescale 1ns/1ps
`default_nettype none

module erx_checker
(
   input logic                    rx_lclk_div4,
   input logic                    rst_n,
   input logic                    rxwr_access,
   input erx_pkg::emesh_packet_t  rxwr_packet,
   input logic                    rxwr_wait,
   input logic                    rxrd_access,
   input erx_pkg::emesh_packet_t  rxrd_packet,
   input logic                    rxrd_wait,
   input logic                    rxrr_access,
   input erx_pkg::emesh_packet_t  rxrr_packet,
   input logic                    rxrr_wait,
   input logic                    rx_wr_wait,
   input logic                    rx_rd_wait
);

   // No queue presents a packet while held in reset
   reset_idle: assert property (@(posedge rx_lclk_div4)
      !rst_n |-> !(rxwr_access || rxrd_access || rxrr_access))
      else $error("queue access high during reset");

   wr_hold: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      (rxwr_access && rxwr_wait) |=> (rxwr_access && $stable(rxwr_packet)))
      else $error("rxwr packet changed while stalled");

   rd_hold: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      (rxrd_access && rxrd_wait) |=> (rxrd_access && $stable(rxrd_packet)))
      else $error("rxrd packet changed while stalled");

   rr_hold: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      (rxrr_access && rxrr_wait) |=> (rxrr_access && $stable(rxrr_packet)))
      else $error("rxrr packet changed while stalled");

   // Pushback always driven
   pushback_known: assert property (@(posedge rx_lclk_div4) disable iff (!rst_n)
      !$isunknown({rx_wr_wait, rx_rd_wait}))
      else $error("pushback output unknown");

endmodule

bind erx erx_checker erx_checker_i
(
   .rx_lclk_div4 (rx_lclk_div4),
   .rst_n        (rst_n),
   .rxwr_access  (rxwr_access),
   .rxwr_packet  (rxwr_packet),
   .rxwr_wait    (rxwr_wait),
   .rxrd_access  (rxrd_access),
   .rxrd_packet  (rxrd_packet),
   .rxrd_wait    (rxrd_wait),
   .rxrr_access  (rxrr_access),
   .rxrr_packet  (rxrr_packet),
   .rxrr_wait    (rxrr_wait),
   .rx_wr_wait   (rx_wr_wait),
   .rx_rd_wait   (rx_rd_wait)
);

`default_nettype wire

// File: bench/erx_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "erx_config.svh"

module erx_tb;

   import erx_pkg::*;

   localparam int         CLK_PERIOD = 20;
   localparam logic [1:0] Q_WR   = 2'd0;
   localparam logic [1:0] Q_RD   = 2'd1;
   localparam logic [1:0] Q_RR   = 2'd2;
   localparam logic [1:0] Q_NONE = 2'd3;  // Frame must vanish

   typedef struct packed
   {
      logic       en;      // Register settings
      logic [1:0] mode;
      chipid_t    sel;
      chipid_t    pat;
      logic [7:0] ctrl;    // Control byte as sent
      addr_t      dst;
      data_t      data;
      addr_t      src;
      logic [2:0] wmask;   // Random wait enables in wr/rd/rr order
      logic [1:0] q;       // Expected queue
   } row_t;

   logic                  rx_lclk_div4;
   logic                  rst_n;
   frame_t                frame_par;
   beat_t                 data_par;
   logic                  mi_en;
   logic                  mi_we;
   logic [`ERX_MI_AW-1:0] mi_addr;
   data_t                 mi_din;
   data_t                 mi_dout;
   logic                  rxwr_access;
   emesh_packet_t         rxwr_packet;
   logic                  rxwr_wait;
   logic                  rxrd_access;
   emesh_packet_t         rxrd_packet;
   logic                  rxrd_wait;
   logic                  rxrr_access;
   emesh_packet_t         rxrr_packet;
   logic                  rxrr_wait;
   logic                  rx_wr_wait;
   logic                  rx_rd_wait;

   row_t          rows[$];
   emesh_packet_t exp_wr[$];   // Scoreboard per queue
   emesh_packet_t exp_rd[$];
   emesh_packet_t exp_rr[$];
   int            err_val;
   int            err_other;
   logic [2:0]    hold_mask;   // Queues stalled for the pushback tests
   logic [2:0]    wait_mask;
   logic [2:0]    next_wait;
   logic          table_built;

   erx UUT
   (
      .rx_lclk_div4 (rx_lclk_div4),
      .rst_n        (rst_n),
      .frame_par    (frame_par),
      .data_par     (data_par),
      .mi_en        (mi_en),
      .mi_we        (mi_we),
      .mi_addr      (mi_addr),
      .mi_din       (mi_din),
      .mi_dout      (mi_dout),
      .rxwr_access  (rxwr_access),
      .rxwr_packet  (rxwr_packet),
      .rxwr_wait    (rxwr_wait),
      .rxrd_access  (rxrd_access),
      .rxrd_packet  (rxrd_packet),
      .rxrd_wait    (rxrd_wait),
      .rxrr_access  (rxrr_access),
      .rxrr_packet  (rxrr_packet),
      .rxrr_wait    (rxrr_wait),
      .rx_wr_wait   (rx_wr_wait),
      .rx_rd_wait   (rx_rd_wait)
   );

   always #(CLK_PERIOD/2) rx_lclk_div4 = ~rx_lclk_div4;

   // Static remap applied bit by bit over the chip ID field
   function automatic addr_t expected_dst(input logic [1:0] mode, input chipid_t sel,
                                          input chipid_t pat, input logic wr, input addr_t dst);
      addr_t r;
      int    b;
      r = dst;
      if (mode == 2'b01 && !(wr && dst[31:20] == `ERX_ID))  // Responses pass untouched
         for (b = 0; b < 12; b++)
            if (sel[b])
               r[20+b] = pat[b];
      return r;
   endfunction

   function automatic emesh_packet_t make_packet(input logic [7:0] ctrl, input addr_t dst,
                                                 input data_t data, input addr_t src);
      emesh_packet_t p;
      p.srcaddr  = src;
      p.data     = data;
      p.dstaddr  = dst;
      p.ctrlmode = ctrl[7:4];
      p.datamode = ctrl[3:2];
      p.write    = ctrl[1];
      p.spare    = 1'b0;       // Reserved bit 0 dropped
      return p;
   endfunction

   // Pushback output that covers queue q
   function automatic logic queue_pushback(input logic [1:0] q);
      return (q == Q_RD) ? rx_rd_wait : rx_wr_wait;
   endfunction

   function automatic logic queue_access(input logic [1:0] q);
      return (q == Q_WR) ? rxwr_access : (q == Q_RD) ? rxrd_access : rxrr_access;
   endfunction

   task automatic add_row(input logic en, input logic [1:0] mode, input chipid_t sel,
                          input chipid_t pat, input logic [7:0] ctrl, input addr_t dst,
                          input logic [2:0] wmask, input logic [1:0] q);
      row_t r;
      r.en    = en;
      r.mode  = mode;
      r.sel   = sel;
      r.pat   = pat;
      r.ctrl  = ctrl;
      r.dst   = dst;
      r.data  = $urandom;
      r.src   = $urandom;
      r.wmask = wmask;
      r.q     = q;
      rows.push_back(r);
   endtask

   // Two beats followed by one idle cycle
   task automatic send_frame(input logic [7:0] ctrl, input addr_t dst,
                             input data_t data, input addr_t src);
      logic [31:0] rnd;
      rnd = $urandom;                            // Junk in unused beat 0 bits
      @(negedge rx_lclk_div4);
      frame_par = '1;
      data_par  = {ctrl, dst, rnd[23:0]};
      @(negedge rx_lclk_div4);
      data_par  = {data, src};
      @(negedge rx_lclk_div4);
      frame_par = '0;
      data_par  = '0;
   endtask

   task automatic mi_write(input int addr, input data_t din);
      @(negedge rx_lclk_div4);
      mi_en   = 1'b1;
      mi_we   = 1'b1;
      mi_addr = addr[`ERX_MI_AW-1:0];
      mi_din  = din;
      @(negedge rx_lclk_div4);
      mi_en   = 1'b0;
      mi_we   = 1'b0;
   endtask

   // Read and compare the registered readback
   task automatic check_reg(input int addr, input data_t exp);
      @(negedge rx_lclk_div4);
      mi_en   = 1'b1;
      mi_we   = 1'b0;
      mi_addr = addr[`ERX_MI_AW-1:0];
      @(negedge rx_lclk_div4);
      mi_en   = 1'b0;
      if (mi_dout !== exp)
      begin
         err_val++;
         $display("ERR t=%0t mi_dout addr=%0d exp=%h got=%h", $time, addr, exp, mi_dout);
      end
   endtask

   task automatic push_expected(input logic [1:0] q, input emesh_packet_t p);
      case (q)
         Q_WR:    exp_wr.push_back(p);
         Q_RD:    exp_rd.push_back(p);
         Q_RR:    exp_rr.push_back(p);
         default: ;
      endcase
   endtask

   // Called when a packet is taken on the coming edge
   task automatic consume(input logic [1:0] q, input string name, input emesh_packet_t got);
      emesh_packet_t exp;
      int            left;
      left = (q == Q_WR) ? exp_wr.size() : (q == Q_RD) ? exp_rd.size() : exp_rr.size();
      if (left == 0)
      begin
         err_other++;
         $display("t=%0t unexpected packet on %s: %h", $time, name, got);
      end
      else
      begin
         case (q)
            Q_WR:    exp = exp_wr.pop_front();
            Q_RD:    exp = exp_rd.pop_front();
            default: exp = exp_rr.pop_front();
         endcase
         if (got !== exp)
         begin
            err_val++;
            $display("ERR t=%0t %s exp=%h got=%h", $time, name, exp, got);
         end
      end
   endtask

   task automatic drain();
      int n;
      n = 0;
      while ((exp_wr.size() + exp_rd.size() + exp_rr.size()) != 0 && n < 300)
      begin
         @(negedge rx_lclk_div4);
         n++;
      end
      if (n >= 300)
      begin
         err_other++;
         $display("t=%0t %0d expected packets never arrived", $time,
                  exp_wr.size() + exp_rd.size() + exp_rr.size());
      end
   endtask

   // Settle the pipe, write the settings and read them back
   task automatic program_regs(input row_t r);
      drain();
      repeat (8) @(negedge rx_lclk_div4);
      mi_write(`ERX_REG_CFG, {29'd0, r.mode, r.en});
      mi_write(`ERX_REG_SEL, {20'd0, r.sel});
      mi_write(`ERX_REG_PAT, {20'd0, r.pat});
      check_reg(`ERX_REG_CFG, {29'd0, r.mode, r.en});
      check_reg(`ERX_REG_SEL, {20'd0, r.sel});
      check_reg(`ERX_REG_PAT, {20'd0, r.pat});
      check_reg(3, '0);                          // Unmapped
      check_reg(15, '0);
   endtask

   // Stall one queue and send until its pushback rises, then release and drain
   task automatic fill_and_release(input logic [1:0] q, input string name);
      logic [7:0] ctrl;
      addr_t      base;
      int         sent;
      data_t      d;
      addr_t      s;
      addr_t      dst;
      ctrl = (q == Q_RD) ? 8'h58 : 8'h36;
      base = (q == Q_WR) ? 32'h0A00_0000 : (q == Q_RD) ? 32'h0B00_0000 : 32'h8000_0000;
      hold_mask = 3'b001 << q;
      sent      = 0;
      while (!queue_pushback(q) && sent < 16)
      begin
         d   = $urandom;
         s   = $urandom;
         dst = base + addr_t'(sent * 4);
         push_expected(q, make_packet(ctrl, dst, d, s));
         send_frame(ctrl, dst, d, s);
         sent++;
      end
      if (!queue_pushback(q))
      begin
         err_other++;
         $display("t=%0t %s pushback did not rise before 16 packets were sent", $time, name);
      end
      repeat (10) @(negedge rx_lclk_div4);
      if (!queue_pushback(q) || !queue_access(q))
      begin
         err_other++;
         $display("t=%0t %s queue did not stay full while stalled", $time, name);
      end
      hold_mask = '0;
      drain();
      repeat (4) @(negedge rx_lclk_div4);
      if (rx_wr_wait || rx_rd_wait)
      begin
         err_other++;
         $display("t=%0t pushback stuck high after the %s queue drained", $time, name);
      end
   endtask

   // Consumer drives the waits on the falling edge
   always @(negedge rx_lclk_div4)
   begin
      if (rst_n)
      begin
         next_wait[0] = hold_mask[0] || (wait_mask[0] && (($urandom & 32'd1) != 0));
         next_wait[1] = hold_mask[1] || (wait_mask[1] && (($urandom & 32'd1) != 0));
         next_wait[2] = hold_mask[2] || (wait_mask[2] && (($urandom & 32'd1) != 0));
         if (rxwr_access && !next_wait[0])
            consume(Q_WR, "rxwr_packet", rxwr_packet);
         if (rxrd_access && !next_wait[1])
            consume(Q_RD, "rxrd_packet", rxrd_packet);
         if (rxrr_access && !next_wait[2])
            consume(Q_RR, "rxrr_packet", rxrr_packet);
         rxwr_wait = next_wait[0];
         rxrd_wait = next_wait[1];
         rxrr_wait = next_wait[2];
      end
   end

   initial
   begin
      wait (table_built);
      #((rows.size() * 40 + 2000) * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles", rows.size() * 40 + 2000);
      $display("Simulation FAILED");
      $finish;
   end

   initial
   begin
      row_t r;
      row_t prev;
      int   i;
      void'($urandom(47705));            // Seed once
      rx_lclk_div4 = 1'b0;
      rst_n        = 1'b0;
      frame_par    = '0;
      data_par     = '0;
      mi_en        = 1'b0;
      mi_we        = 1'b0;
      mi_addr      = '0;
      mi_din       = '0;
      rxwr_wait    = 1'b0;
      rxrd_wait    = 1'b0;
      rxrr_wait    = 1'b0;
      hold_mask    = '0;
      wait_mask    = '0;
      err_val      = 0;
      err_other    = 0;
      table_built  = 1'b0;

      // en mode sel pat ctrl dst wmask queue
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h36, 32'h1234_5678, 3'b000, Q_WR);  // Plain writes
      add_row(1, 2'd0, 12'h000, 12'h000, 8'hAE, 32'h0010_0004, 3'b001, Q_WR);
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h37, 32'hFFF0_0000, 3'b001, Q_WR);
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h58, 32'h2000_0100, 3'b010, Q_RD);
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h04, 32'h800F_FFFC, 3'b000, Q_RD);  // Read to own ID
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h36, 32'h8000_0040, 3'b100, Q_RR);
      add_row(1, 2'd0, 12'h000, 12'h000, 8'hAE, 32'h8001_2340, 3'b100, Q_RR);
      add_row(1, 2'd1, 12'hF00, 12'h300, 8'h36, 32'h1234_5678, 3'b000, Q_WR);  // Static remap
      add_row(1, 2'd1, 12'hF00, 12'h300, 8'h58, 32'hABC0_0010, 3'b010, Q_RD);
      add_row(1, 2'd1, 12'hF00, 12'h300, 8'h36, 32'h8000_0008, 3'b100, Q_RR);
      add_row(1, 2'd1, 12'hF00, 12'h300, 8'h04, 32'h8000_0010, 3'b000, Q_RD);
      add_row(1, 2'd1, 12'h0F0, 12'h0A0, 8'h37, 32'h5550_1000, 3'b001, Q_WR);
      add_row(1, 2'd1, 12'h0F0, 12'h0A0, 8'h58, 32'h0FF0_0000, 3'b010, Q_RD);
      add_row(1, 2'd1, 12'h0F0, 12'h0A0, 8'hAE, 32'h8000_FFFF, 3'b111, Q_RR);
      add_row(1, 2'd1, 12'h0F0, 12'h0A0, 8'h36, 32'h7C00_0000, 3'b111, Q_WR);
      add_row(1, 2'd2, 12'hFFF, 12'h123, 8'h36, 32'h4560_0000, 3'b000, Q_WR);  // Code 2 is none
      add_row(1, 2'd2, 12'hFFF, 12'h123, 8'h58, 32'h4560_0004, 3'b000, Q_RD);
      add_row(0, 2'd0, 12'h000, 12'h000, 8'h36, 32'h1111_0000, 3'b000, Q_NONE); // Disabled
      add_row(0, 2'd0, 12'h000, 12'h000, 8'h58, 32'h2222_0000, 3'b000, Q_NONE);
      add_row(0, 2'd0, 12'h000, 12'h000, 8'h36, 32'h8000_0000, 3'b000, Q_NONE);
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h36, 32'h3333_0000, 3'b000, Q_WR);  // Enabled again
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h58, 32'h4444_0000, 3'b010, Q_RD);
      add_row(1, 2'd0, 12'h000, 12'h000, 8'hAE, 32'h8000_1000, 3'b000, Q_RR);
      add_row(1, 2'd0, 12'h000, 12'h000, 8'h37, 32'h0000_0000, 3'b001, Q_WR);
      table_built = 1'b1;

      repeat (4) @(negedge rx_lclk_div4);
      rst_n = 1'b1;
      @(negedge rx_lclk_div4);
      if (rxwr_access || rxrd_access || rxrr_access || rx_wr_wait || rx_rd_wait)
      begin
         err_other++;
         $display("t=%0t an access or pushback output is high after reset", $time);
      end
      check_reg(`ERX_REG_CFG, 32'd1);            // Enabled with remap none

      for (i = 0; i < rows.size(); i++)
      begin
         r = rows[i];
         if (i == 0 || {r.en, r.mode, r.sel, r.pat} != {prev.en, prev.mode, prev.sel, prev.pat})
            program_regs(r);
         prev      = r;
         wait_mask = r.wmask;
         while (rx_wr_wait || rx_rd_wait)
            @(negedge rx_lclk_div4);               // Obey pushback
         push_expected(r.q, make_packet(r.ctrl,
                       expected_dst(r.mode, r.sel, r.pat, r.ctrl[1], r.dst), r.data, r.src));
         send_frame(r.ctrl, r.dst, r.data, r.src);
      end

      // Stall each queue in turn until its pushback rises
      prev.en   = 1'b1;
      prev.mode = 2'd0;
      prev.sel  = '0;
      prev.pat  = '0;
      program_regs(prev);
      wait_mask = '0;
      fill_and_release(Q_WR, "rxwr");
      fill_and_release(Q_RD, "rxrd");
      fill_and_release(Q_RR, "rxrr");

      $display("Errors: %0d value mismatches, %0d other failures", err_val, err_other);
      if (err_val == 0 && err_other == 0)
         $display("Simulation PASSED");
      else
         $display("Simulation FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// File: vlog.f
+incdir+include
logic/erx_pkg.sv
logic/erx_cfg.sv
logic/erx_protocol.sv
logic/erx_remap.sv
logic/erx_disty.sv
logic/erx_fifo.sv
logic/erx.sv
bench/erx_checker.sv
bench/erx_tb.sv

// File: Makefile
# Verilator simulation of the receiver testbench

VERILATOR ?= verilator
TOP       ?= erx_tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
PASS_MSG  ?= Simulation PASSED
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ps -j 0

.PHONY: sim clean

# Build, run, then search the output for the pass line
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
